/* hw/irq_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_collector (
  input  logic       clk,
  input  logic       reset,
  mcu_frame_if.regs  frame,
  input  logic [7:0] int_in,
  output logic       int_out_n,
  output logic [7:0] irq_pending,
  output logic [7:0] int_ack
);

  logic [7:0] int_sync_0;
  logic [7:0] int_sync_1;
  logic       ack_byte;

  // First payload byte of an irq frame is the acknowledge mask
  assign ack_byte = frame.valid && (frame.command == sysctrl_pkg::cmd_irq) &&
                    (frame.byte_idx == 4'd1);

  // Host reads back the synchronized lines
  assign irq_pending = int_sync_1;

  always_ff @(posedge clk) begin
    if (reset) begin
      int_sync_0 <= 8'h00;
      int_sync_1 <= 8'h00;
      int_out_n  <= 1'b1;
      int_ack    <= 8'h00;
    end else begin
      // Interrupt sources may run on other clocks
      int_sync_0 <= int_in;
      int_sync_1 <= int_sync_0;
      // Request is active low while any line is pending
      int_out_n  <= ~|int_sync_1;
      // Mask shows for one cycle only
      int_ack    <= ack_byte ? frame.payload : 8'h00;
    end
  end

  // Acknowledge is a single cycle pulse
  assert property (@(posedge clk) disable iff (reset)
    (int_ack != 8'h00) |=> (int_ack == 8'h00));

endmodule

`default_nettype wire

/* hw/led_color_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module led_color_regs (
  input  logic        clk,
  input  logic        reset,
  mcu_frame_if.regs   frame,
  output logic [1:0]  leds,
  output logic [23:0] color
);

  logic       led_byte;
  logic       color_byte;
  logic [7:0] payload_rev;

  assign led_byte   = frame.valid && (frame.command == sysctrl_pkg::cmd_leds);
  assign color_byte = frame.valid && (frame.command == sysctrl_pkg::cmd_color);

  // Host sends colour bytes LSB first
  assign payload_rev = {<<{frame.payload}};

  // LEDs off and colour black out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      leds  <= 2'b00;
      color <= 24'h000000;
    end else begin
      if (led_byte && frame.byte_idx == 4'd1) begin
        leds <= frame.payload[1:0];
      end
      // Byte order is 15:8, 7:0, then 23:16
      if (color_byte) begin
        if (frame.byte_idx == 4'd1) color[15:8]  <= payload_rev;
        if (frame.byte_idx == 4'd2) color[7:0]   <= payload_rev;
        if (frame.byte_idx == 4'd3) color[23:16] <= payload_rev;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/mcu_frame_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_frame_decoder (
  input  logic         clk,
  input  logic         reset,
  input  logic         data_in_strobe,
  input  logic         data_in_start,
  input  logic [7:0]   data_in,
  input  logic [1:0]   buttons,
  input  logic [7:0]   irq_pending,
  output logic [7:0]   data_out,
  mcu_frame_if.decoder frame
);

  logic       frame_open;
  logic [7:0] command;
  logic [3:0] byte_idx;
  logic       start_strobe;
  logic       payload_strobe;
  logic       reply_valid;
  logic [7:0] reply;

  assign start_strobe = data_in_strobe && data_in_start;
  // Payload bytes only count inside an open frame
  assign payload_strobe = data_in_strobe && !data_in_start && frame_open;

  // Reply for the byte being received
  always_comb begin
    reply_valid = 1'b0;
    reply       = 8'h00;
    if (command == sysctrl_pkg::cmd_status) begin
      reply_valid = (byte_idx >= 4'd1) && (byte_idx <= 4'd3);
      if (byte_idx == 4'd1) reply = sysctrl_pkg::status_sig_0;
      if (byte_idx == 4'd2) reply = sysctrl_pkg::status_sig_1;
      if (byte_idx == 4'd3) reply = sysctrl_pkg::core_id;
    end else if (command == sysctrl_pkg::cmd_buttons) begin
      reply_valid = 1'b1;
      reply       = {6'b000000, buttons};
    end else if (command == sysctrl_pkg::cmd_irq) begin
      // Every byte of an irq frame reads the pending lines
      reply_valid = 1'b1;
      reply       = irq_pending;
    end
  end

  // Frame tracking and reply register
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_open  <= 1'b0;
      byte_idx    <= 4'd0;
      frame.valid <= 1'b0;
      data_out    <= 8'h00;
    end else begin
      frame.valid <= payload_strobe;
      if (start_strobe) begin
        // A start byte always restarts, even mid-frame
        frame_open <= 1'b1;
        byte_idx   <= 4'd1;
      end else if (payload_strobe && byte_idx != sysctrl_pkg::byte_idx_max) begin
        byte_idx <= byte_idx + 4'd1;
      end
      if (payload_strobe && reply_valid) begin
        data_out <= reply;
      end
    end
  end

  // Command and broadcast byte, qualified by valid
  always_ff @(posedge clk) begin
    if (start_strobe) begin
      command <= data_in;
    end
    if (payload_strobe) begin
      frame.command  <= command;
      frame.byte_idx <= byte_idx;
      frame.payload  <= data_in;
    end
  end

  // Index sticks at its maximum until the next start byte
  assert property (@(posedge clk) disable iff (reset)
    (byte_idx == sysctrl_pkg::byte_idx_max && !start_strobe)
      |=> (byte_idx == sysctrl_pkg::byte_idx_max));

  // No byte reaches the register blocks outside a frame
  assert property (@(posedge clk) disable iff (reset)
    !frame_open |=> !frame.valid);

endmodule

`default_nettype wire

/* hw/mcu_frame_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One payload byte of a host frame, broadcast to all register blocks
interface mcu_frame_if;

  // Single cycle pulse per payload byte
  logic       valid;
  // Command byte of the frame this byte belongs to
  logic [7:0] command;
  // Position of the byte within the frame, 1 for the first payload byte
  logic [3:0] byte_idx;
  logic [7:0] payload;

  modport decoder (
    output valid,
    output command,
    output byte_idx,
    output payload
  );

  modport regs (
    input valid,
    input command,
    input byte_idx,
    input payload
  );

endinterface

`default_nettype wire

/* hw/osd_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module osd_config_regs (
  input  logic                     clk,
  input  logic                     reset,
  mcu_frame_if.regs                frame,
  output sysctrl_pkg::osd_config_t osd_config
);

  logic [7:0] cfg_id;
  logic       cfg_byte;
  logic       id_byte;
  logic       value_byte;

  assign cfg_byte   = frame.valid && (frame.command == sysctrl_pkg::cmd_config);
  // Byte 1 names the setting, byte 2 carries its value
  assign id_byte    = cfg_byte && (frame.byte_idx == 4'd1);
  assign value_byte = cfg_byte && (frame.byte_idx == 4'd2);

  always_ff @(posedge clk) begin
    if (id_byte) begin
      cfg_id <= frame.payload;
    end
  end

  // Write the field selected by the stored id
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_config <= sysctrl_pkg::osd_config_default;
    end else if (value_byte) begin
      case (cfg_id)
        sysctrl_pkg::cfg_id_chipset:   osd_config.chipset      <= frame.payload[1:0];
        sysctrl_pkg::cfg_id_memory:    osd_config.memory       <= frame.payload[0];
        sysctrl_pkg::cfg_id_reu:       osd_config.reu_cfg      <= frame.payload[0];
        // Run 0, reset 1, coldboot 3
        sysctrl_pkg::cfg_id_reset:     osd_config.reset_mode   <= frame.payload[1:0];
        // None, 25, 50 or 75 percent
        sysctrl_pkg::cfg_id_scanlines: osd_config.scanlines    <= frame.payload[1:0];
        // Mute up to full volume
        sysctrl_pkg::cfg_id_volume:    osd_config.volume       <= frame.payload[1:0];
        // 4:3 or 16:9
        sysctrl_pkg::cfg_id_wide:      osd_config.wide_screen  <= frame.payload[0];
        // One write protect bit per drive
        sysctrl_pkg::cfg_id_wprot:     osd_config.floppy_wprot <= frame.payload[1:0];
        sysctrl_pkg::cfg_id_port1:     osd_config.port_1       <= frame.payload[2:0];
        sysctrl_pkg::cfg_id_port2:     osd_config.port_2       <= frame.payload[2:0];
        sysctrl_pkg::cfg_id_dos:       osd_config.dos_sel      <= frame.payload[1:0];
        sysctrl_pkg::cfg_id_1541:      osd_config.c1541_reset  <= frame.payload[0];
        // Unknown ids leave every field alone
        default: ;
      endcase
    end
  end

  // Defaults are in place right after reset
  assert property (@(posedge clk)
    $past(reset) |-> (osd_config == sysctrl_pkg::osd_config_default));

endmodule

`default_nettype wire

/* hw/sysctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sysctrl (
  input  logic        clk,
  input  logic        reset,
  // Host byte link
  input  logic        data_in_strobe,
  input  logic        data_in_start,
  input  logic [7:0]  data_in,
  output logic [7:0]  data_out,
  // Interrupts
  input  logic [7:0]  int_in,
  output logic        int_out_n,
  output logic [7:0]  int_ack,
  // Board buttons S0 and S1
  input  logic [1:0]  buttons,
  output logic [1:0]  leds,
  // RGB value for the WS2812
  output logic [23:0] color,
  // OSD configuration
  output logic [1:0]  system_chipset,
  output logic        system_memory,
  output logic        system_reu_cfg,
  output logic [1:0]  system_reset,
  output logic [1:0]  system_scanlines,
  output logic [1:0]  system_volume,
  output logic        system_wide_screen,
  output logic [1:0]  system_floppy_wprot,
  output logic [2:0]  system_port_1,
  output logic [2:0]  system_port_2,
  output logic [1:0]  system_dos_sel,
  output logic        system_1541_reset
);

  logic [7:0]               irq_pending;
  sysctrl_pkg::osd_config_t osd_config;

  mcu_frame_if frame ();

  mcu_frame_decoder i_mcu_frame_decoder (
    .clk            (clk),
    .reset          (reset),
    .data_in_strobe (data_in_strobe),
    .data_in_start  (data_in_start),
    .data_in        (data_in),
    .buttons        (buttons),
    .irq_pending    (irq_pending),
    .data_out       (data_out),
    .frame          (frame.decoder)
  );

  osd_config_regs i_osd_config_regs (
    .clk        (clk),
    .reset      (reset),
    .frame      (frame.regs),
    .osd_config (osd_config)
  );

  led_color_regs i_led_color_regs (
    .clk   (clk),
    .reset (reset),
    .frame (frame.regs),
    .leds  (leds),
    .color (color)
  );

  irq_collector i_irq_collector (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame.regs),
    .int_in      (int_in),
    .int_out_n   (int_out_n),
    .irq_pending (irq_pending),
    .int_ack     (int_ack)
  );

  // Config fields out to the core
  assign system_chipset      = osd_config.chipset;
  assign system_memory       = osd_config.memory;
  assign system_reu_cfg      = osd_config.reu_cfg;
  assign system_reset        = osd_config.reset_mode;
  assign system_scanlines    = osd_config.scanlines;
  assign system_volume       = osd_config.volume;
  assign system_wide_screen  = osd_config.wide_screen;
  assign system_floppy_wprot = osd_config.floppy_wprot;
  assign system_port_1       = osd_config.port_1;
  assign system_port_2       = osd_config.port_2;
  assign system_dos_sel      = osd_config.dos_sel;
  assign system_1541_reset   = osd_config.c1541_reset;

endmodule

`default_nettype wire

/* hw/sysctrl_pkg.sv */
`default_nettype none

package sysctrl_pkg;

  // Host command codes, first byte of every frame
  localparam logic [7:0] cmd_status  = 8'd0;
  localparam logic [7:0] cmd_leds    = 8'd1;
  localparam logic [7:0] cmd_color   = 8'd2;
  localparam logic [7:0] cmd_buttons = 8'd3;
  localparam logic [7:0] cmd_config  = 8'd4;
  localparam logic [7:0] cmd_irq     = 8'd5;

  // Status reply pattern
  // Unlikely to show up on an unprogrammed device
  localparam logic [7:0] status_sig_0 = 8'h5c;
  localparam logic [7:0] status_sig_1 = 8'h42;
  localparam logic [7:0] core_id      = 8'h02;

  // Byte index stops counting here
  localparam logic [3:0] byte_idx_max = 4'd15;

  // OSD config ids, one ASCII character each
  localparam logic [7:0] cfg_id_chipset   = "C";
  localparam logic [7:0] cfg_id_memory    = "M";
  localparam logic [7:0] cfg_id_reu       = "V";
  localparam logic [7:0] cfg_id_reset     = "R";
  localparam logic [7:0] cfg_id_scanlines = "S";
  localparam logic [7:0] cfg_id_volume    = "A";
  localparam logic [7:0] cfg_id_wide      = "W";
  localparam logic [7:0] cfg_id_wprot     = "P";
  localparam logic [7:0] cfg_id_port1     = "Q";
  localparam logic [7:0] cfg_id_port2     = "J";
  localparam logic [7:0] cfg_id_dos       = "D";
  localparam logic [7:0] cfg_id_1541      = "Z";

  // User settings from the on-screen menu
  typedef struct packed {
    logic [1:0] chipset;
    logic       memory;
    // REU none or 512K
    logic       reu_cfg;
    // Run, reset or coldboot
    logic [1:0] reset_mode;
    logic [1:0] scanlines;
    logic [1:0] volume;
    logic       wide_screen;
    logic [1:0] floppy_wprot;
    // Joystick input device selection
    logic [2:0] port_1;
    logic [2:0] port_2;
    logic [1:0] dos_sel;
    logic       c1541_reset;
  } osd_config_t;

  // Power-up values until the host sends its own
  localparam osd_config_t osd_config_default = '{
    chipset:      2'd0,
    memory:       1'b0,
    reu_cfg:      1'b0,
    reset_mode:   2'd0,
    scanlines:    2'd0,
    volume:       2'd2,
    wide_screen:  1'b0,
    floppy_wprot: 2'd0,
    port_1:       3'd0,
    port_2:       3'd1,
    dos_sel:      2'd0,
    c1541_reset:  1'b0
  };

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the sysctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module sysctrl_tb \
  -f sysctrl.f --Mdir "$OBJ" -o sim_sysctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_sysctrl" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sysctrl.f */
hw/sysctrl_pkg.sv
hw/mcu_frame_if.sv
hw/mcu_frame_decoder.sv
hw/osd_config_regs.sv
hw/led_color_regs.sv
hw/irq_collector.sv
hw/sysctrl.sv
verif/sysctrl_tb.sv

/* verif/sysctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sysctrl_tb;

  // Watchdog budget, frames times cycles per frame, doubled for margin
  localparam int num_frames       = 70;
  localparam int bytes_per_frame  = 6;
  localparam int cycles_per_frame = 2 * bytes_per_frame + 10;
  localparam int timeout_ns       = 2 * num_frames * cycles_per_frame * 10 + 200;

  // Known OSD ids, ASCII
  localparam logic [7:0] id_table [12] = '{"C", "M", "V", "R", "S", "A",
                                            "W", "P", "Q", "J", "D", "Z"};

  logic        clk = 1'b0;
  logic        reset;
  logic        data_in_strobe;
  logic        data_in_start;
  logic [7:0]  data_in;
  logic [7:0]  data_out;
  logic [7:0]  int_in;
  logic        int_out_n;
  logic [7:0]  int_ack;
  logic [1:0]  buttons;
  logic [1:0]  leds;
  logic [23:0] color;
  logic [1:0]  system_chipset;
  logic        system_memory;
  logic        system_reu_cfg;
  logic [1:0]  system_reset;
  logic [1:0]  system_scanlines;
  logic [1:0]  system_volume;
  logic        system_wide_screen;
  logic [1:0]  system_floppy_wprot;
  logic [2:0]  system_port_1;
  logic [2:0]  system_port_2;
  logic [1:0]  system_dos_sel;
  logic        system_1541_reset;

  // Model state
  sysctrl_pkg::osd_config_t exp_cfg;
  logic [1:0]  exp_leds;
  logic [23:0] exp_color;
  logic [7:0]  exp_data_out;
  logic [7:0]  exp_ack;
  int          exp_ack_total;
  logic        m_open;
  logic [7:0]  m_cmd;
  logic [3:0]  m_idx;
  logic [7:0]  m_id;
  logic [7:0]  exp_replies[$];
  logic [7:0]  got_replies[$];
  logic [7:0]  pq[$];

  // Ack pulse monitor
  int          ack_total = 0;
  logic [7:0]  ack_last = 8'h00;

  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          err_mark = 0;
  integer      seed;
  int          rnd;
  int          pick;
  logic [7:0]  id;
  event        check_ev;

  sysctrl i_sysctrl (
    .clk                 (clk),
    .reset               (reset),
    .data_in_strobe      (data_in_strobe),
    .data_in_start       (data_in_start),
    .data_in             (data_in),
    .data_out            (data_out),
    .int_in              (int_in),
    .int_out_n           (int_out_n),
    .int_ack             (int_ack),
    .buttons             (buttons),
    .leds                (leds),
    .color               (color),
    .system_chipset      (system_chipset),
    .system_memory       (system_memory),
    .system_reu_cfg      (system_reu_cfg),
    .system_reset        (system_reset),
    .system_scanlines    (system_scanlines),
    .system_volume       (system_volume),
    .system_wide_screen  (system_wide_screen),
    .system_floppy_wprot (system_floppy_wprot),
    .system_port_1       (system_port_1),
    .system_port_2       (system_port_2),
    .system_dos_sel      (system_dos_sel),
    .system_1541_reset   (system_1541_reset)
  );

  always #5 clk = ~clk;

  function automatic logic [7:0] reverse_byte(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7 - i];
    end
    return r;
  endfunction

  // Volume 2 and port 2 on device 1, all else zero
  function automatic sysctrl_pkg::osd_config_t default_config();
    sysctrl_pkg::osd_config_t c;
    c = '0;
    c.volume = 2'd2;
    c.port_2 = 3'd1;
    return c;
  endfunction

  // One id/value pair applied to the config, unknown ids ignored
  function automatic sysctrl_pkg::osd_config_t expected_config(
    input sysctrl_pkg::osd_config_t cfg,
    input logic [7:0]               cfg_id,
    input logic [7:0]               value
  );
    sysctrl_pkg::osd_config_t c;
    c = cfg;
    case (cfg_id)
      "C":     c.chipset      = value[1:0];
      "M":     c.memory       = value[0];
      "V":     c.reu_cfg      = value[0];
      "R":     c.reset_mode   = value[1:0];
      "S":     c.scanlines    = value[1:0];
      "A":     c.volume       = value[1:0];
      "W":     c.wide_screen  = value[0];
      "P":     c.floppy_wprot = value[1:0];
      "Q":     c.port_1       = value[2:0];
      "J":     c.port_2       = value[2:0];
      "D":     c.dos_sel      = value[1:0];
      "Z":     c.c1541_reset  = value[0];
      default: ;
    endcase
    return c;
  endfunction

  // Frame tracking and register effects of one host byte
  task automatic model_byte(input logic start, input logic [7:0] data);
    if (start) begin
      m_open = 1'b1;
      m_cmd  = data;
      m_idx  = 4'd1;
    end else begin
      if (m_open) begin
        case (m_cmd)
          sysctrl_pkg::cmd_status: begin
            if (m_idx == 4'd1) exp_data_out = 8'h5c;
            if (m_idx == 4'd2) exp_data_out = 8'h42;
            if (m_idx == 4'd3) exp_data_out = 8'h02;
          end
          sysctrl_pkg::cmd_buttons: exp_data_out = {6'b000000, buttons};
          sysctrl_pkg::cmd_irq: begin
            exp_data_out = int_in;
            if (m_idx == 4'd1 && data != 8'h00) begin
              exp_ack       = data;
              exp_ack_total = exp_ack_total + 1;
            end
          end
          sysctrl_pkg::cmd_leds: if (m_idx == 4'd1) exp_leds = data[1:0];
          sysctrl_pkg::cmd_color: begin
            if (m_idx == 4'd1) exp_color[15:8]  = reverse_byte(data);
            if (m_idx == 4'd2) exp_color[7:0]   = reverse_byte(data);
            if (m_idx == 4'd3) exp_color[23:16] = reverse_byte(data);
          end
          sysctrl_pkg::cmd_config: begin
            if (m_idx == 4'd1) m_id = data;
            if (m_idx == 4'd2) exp_cfg = expected_config(exp_cfg, m_id, data);
          end
          default: ;
        endcase
        // Index saturates at 15
        if (m_idx != 4'd15) m_idx = m_idx + 4'd1;
      end
      exp_replies.push_back(exp_data_out);
    end
  endtask

  // One strobe, then an idle cycle
  task automatic send_byte(input logic start, input logic [7:0] data);
    data_in_strobe = 1'b1;
    data_in_start  = start;
    data_in        = data;
    model_byte(start, data);
    @(posedge clk);
    #1;
    data_in_strobe = 1'b0;
    data_in_start  = 1'b0;
    if (!start) got_replies.push_back(data_out);
    @(posedge clk);
    #1;
  endtask

  task automatic send_frame(input logic [7:0] cmd);
    send_byte(1'b1, cmd);
    foreach (pq[i]) send_byte(1'b0, pq[i]);
    pq.delete();
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset        = 1'b0;
    m_open       = 1'b0;
    m_idx        = 4'd0;
    exp_cfg      = default_config();
    exp_leds     = 2'b00;
    exp_color    = 24'h000000;
    exp_data_out = 8'h00;
  endtask

  // Registers settle 2 edges after the last strobe, ack seen one edge later
  task automatic check_frame();
    repeat (4) @(posedge clk);
    #1;
    -> check_ev;
    @(posedge clk);
    #1;
    exp_replies.delete();
    got_replies.delete();
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != err_mark) failed_tests++;
    $display("%s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  always @(posedge clk) begin
    if (int_ack != 8'h00) begin
      ack_total <= ack_total + 1;
      ack_last  <= int_ack;
    end
  end

  // Compare DUT outputs with the model after each frame
  always @(check_ev) begin
    if (got_replies.size() != exp_replies.size()) begin
      errors++;
      $display("error: reply count mismatch, %0d bytes captured but %0d expected",
               got_replies.size(), exp_replies.size());
    end else begin
      foreach (got_replies[i]) begin
        compare($sformatf("data_out byte %0d", i), 32'(got_replies[i]), 32'(exp_replies[i]));
      end
    end
    compare("data_out", 32'(data_out), 32'(exp_data_out));
    compare("leds", 32'(leds), 32'(exp_leds));
    compare("color", 32'(color), 32'(exp_color));
    compare("int_out_n", 32'(int_out_n), 32'(int_in == 8'h00));
    compare("int_ack pulse count", 32'(ack_total), 32'(exp_ack_total));
    compare("int_ack", 32'(ack_last), 32'(exp_ack));
    compare("system_chipset", 32'(system_chipset), 32'(exp_cfg.chipset));
    compare("system_memory", 32'(system_memory), 32'(exp_cfg.memory));
    compare("system_reu_cfg", 32'(system_reu_cfg), 32'(exp_cfg.reu_cfg));
    compare("system_reset", 32'(system_reset), 32'(exp_cfg.reset_mode));
    compare("system_scanlines", 32'(system_scanlines), 32'(exp_cfg.scanlines));
    compare("system_volume", 32'(system_volume), 32'(exp_cfg.volume));
    compare("system_wide_screen", 32'(system_wide_screen), 32'(exp_cfg.wide_screen));
    compare("system_floppy_wprot", 32'(system_floppy_wprot), 32'(exp_cfg.floppy_wprot));
    compare("system_port_1", 32'(system_port_1), 32'(exp_cfg.port_1));
    compare("system_port_2", 32'(system_port_2), 32'(exp_cfg.port_2));
    compare("system_dos_sel", 32'(system_dos_sel), 32'(exp_cfg.dos_sel));
    compare("system_1541_reset", 32'(system_1541_reset), 32'(exp_cfg.c1541_reset));
  end

  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns, simulation did not finish", timeout_ns);
    $display("Test failed");
    $finish;
  end

  initial begin
    seed           = 32'h192a_ef20;
    data_in_strobe = 1'b0;
    data_in_start  = 1'b0;
    data_in        = 8'h00;
    int_in         = 8'h00;
    buttons        = 2'b00;
    exp_ack        = 8'h00;
    exp_ack_total  = 0;
    m_cmd          = 8'h00;
    m_id           = 8'h00;
    apply_reset();

    // Signature bytes, then each button pattern
    repeat (3) pq.push_back(8'h00);
    send_frame(sysctrl_pkg::cmd_status);
    for (int b = 0; b < 4; b++) begin
      buttons = b[1:0];
      pq.push_back(8'h00);
      send_frame(sysctrl_pkg::cmd_buttons);
    end
    check_frame();
    end_test("status_buttons");

    pq.push_back(8'hfe);
    send_frame(sysctrl_pkg::cmd_leds);
    check_frame();
    pq.push_back(8'h05);
    send_frame(sysctrl_pkg::cmd_leds);
    check_frame();
    rnd = $random(seed);
    pq.push_back(rnd[7:0]);
    pq.push_back(rnd[15:8]);
    pq.push_back(rnd[23:16]);
    send_frame(sysctrl_pkg::cmd_color);
    check_frame();
    end_test("leds_color");

    // Defaults first, then random pairs with some unknown ids
    apply_reset();
    check_frame();
    for (int n = 0; n < 40; n++) begin
      rnd  = $random(seed);
      pick = rnd & 32'hf;
      if (pick < 12) id = id_table[pick];
      else id = 8'(96 + pick);
      pq.push_back(id);
      pq.push_back(rnd[15:8]);
      send_frame(sysctrl_pkg::cmd_config);
      check_frame();
    end
    end_test("config");

    for (int n = 0; n < 4; n++) begin
      rnd    = $random(seed);
      int_in = (n == 0) ? 8'h00 : rnd[7:0];
      // Let the synchronizer settle
      repeat (4) @(posedge clk);
      #1;
      pq.push_back(rnd[15:8] | 8'h01);
      pq.push_back(8'h00);
      send_frame(sysctrl_pkg::cmd_irq);
      check_frame();
    end
    int_in = 8'h00;
    repeat (4) @(posedge clk);
    #1;
    end_test("interrupts");

    // Stray payload with no frame open
    apply_reset();
    send_byte(1'b0, 8'h03);
    send_byte(1'b0, 8'h55);
    check_frame();
    // Config frame cut short by an LED frame
    send_byte(1'b1, sysctrl_pkg::cmd_config);
    send_byte(1'b0, "A");
    pq.push_back(8'h03);
    send_frame(sysctrl_pkg::cmd_leds);
    check_frame();
    // Only the first pair counts
    pq.push_back("S");
    pq.push_back(8'h02);
    pq.push_back("A");
    pq.push_back(8'h01);
    pq.push_back(8'h03);
    send_frame(sysctrl_pkg::cmd_config);
    check_frame();
    end_test("framing");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
